/* rtl/mem_bank_engine.sv */
`timescale 1ns/1ns

module mem_bank_engine import mem_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  bank_req_t bank_req,
    input  logic      rsp_pop,
    output logic      bank_ready,
    output bank_rsp_t bank_rsp
);

    bank_state_e         state;
    bank_req_t           cur;
    logic                row_open;
    logic [ROW_BITS-1:0] open_row;
    logic [WAIT_W-1:0]   wait_cnt;
    logic                take;
    logic                row_hit;
    logic                rsp_valid;
    logic [DATA_W-1:0]   rsp_data;

    // Row by column storage
    logic [DATA_W-1:0] mem [ROWS][COLS];

    // Idle and nothing waiting for the return side
    assign bank_ready = (state == BANK_IDLE) && !rsp_valid;
    assign take       = req_valid && bank_ready;
    assign row_hit    = row_open && (open_row == bank_req.row);

    assign bank_rsp.valid = rsp_valid;
    assign bank_rsp.data  = rsp_data;

    // ************************************************************************
    // Row FSM
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= BANK_IDLE;
            row_open  <= 1'b0;
            open_row  <= '0;
            wait_cnt  <= '0;
            rsp_valid <= 1'b0;
        end else begin
            // Return module collects the held word
            if (rsp_pop) begin
                rsp_valid <= 1'b0;
            end
            case (state)
                BANK_IDLE: begin
                    if (take) begin
                        if (row_hit) begin
                            state <= BANK_ACCESS;
                        end else if (!row_open) begin
                            state    <= BANK_ACTIVATE;
                            wait_cnt <= WAIT_W'(T_RCD - 1);
                        end else begin
                            // Wrong row open, close it first
                            state    <= BANK_PRECHARGE;
                            wait_cnt <= WAIT_W'(T_RP - 1);
                        end
                    end
                end
                BANK_PRECHARGE: begin
                    if (wait_cnt == '0) begin
                        state    <= BANK_ACTIVATE;
                        row_open <= 1'b0;
                        wait_cnt <= WAIT_W'(T_RCD - 1);
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                BANK_ACTIVATE: begin
                    if (wait_cnt == '0) begin
                        state    <= BANK_ACCESS;
                        row_open <= 1'b1;
                        open_row <= cur.row;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                BANK_ACCESS: begin
                    state <= BANK_IDLE;
                    if (cur.op == CMD_READ) begin
                        rsp_valid <= 1'b1;
                    end
                end
                default: state <= BANK_IDLE;
            endcase
        end
    end

    // ************************************************************************
    // Datapath
    // ************************************************************************
    // Latch the request when the bank takes it
    always_ff @(posedge clk) begin
        if (take) begin
            cur <= bank_req;
        end
    end

    // Byte merge on writes, word copy into the hold on reads
    always_ff @(posedge clk) begin
        if (state == BANK_ACCESS) begin
            if (cur.op == CMD_WRITE) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (cur.strb[i]) begin
                        mem[cur.row][cur.col][i*8 +: 8] <= cur.data[i*8 +: 8];
                    end
                end
            end else begin
                rsp_data <= mem[cur.row][cur.col];
            end
        end
    end

endmodule

/* rtl/mem_cmd_front.sv */
`timescale 1ns/1ns

module mem_cmd_front import mem_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_en,
    input  mem_cmd_e             cmd,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [DATA_W-1:0]    wr_data,
    input  logic [STRB_W-1:0]    wr_strb,
    input  logic [NUM_BANKS-1:0] bank_ready,
    input  logic                 order_full,
    output logic                 cmd_ready,
    output logic                 init_calib_complete,
    output logic [NUM_BANKS-1:0] req_valid,
    output bank_req_t            bank_req [NUM_BANKS],
    output logic                 order_push,
    output logic [BANK_BITS-1:0] order_bank
);

    logic [INIT_CNT_W-1:0] init_cnt;
    logic                  init_issue;
    logic                  sweep_done;
    logic [NUM_BANKS-1:0]  bank_free;
    logic [BANK_BITS-1:0]  dec_bank;
    logic                  accept;
    bank_req_t             cmd_req;
    bank_req_t             init_req;

    // ************************************************************************
    // Address decode
    // ************************************************************************
    // Word address, col in 2..0, bank in 4..3, row in 6..5
    assign dec_bank = addr[COL_BITS +: BANK_BITS];

    always_comb begin
        cmd_req.op   = cmd;
        cmd_req.row  = addr[COL_BITS + BANK_BITS +: ROW_BITS];
        cmd_req.col  = addr[COL_BITS-1:0];
        cmd_req.data = wr_data;
        cmd_req.strb = wr_strb;
    end

    // Sweep step, zero write with every byte enabled
    always_comb begin
        init_req.op   = CMD_WRITE;
        init_req.row  = init_cnt[COL_BITS +: ROW_BITS];
        init_req.col  = init_cnt[COL_BITS-1:0];
        init_req.data = '0;
        init_req.strb = '1;
    end

    assign sweep_done = (init_cnt == INIT_CNT_W'(INIT_CYCLES));
    // Next sweep step once every pending request is gone or leaving
    assign init_issue = !init_calib_complete && !sweep_done && (&(~req_valid | bank_ready));

    // Bank busy from acceptance until it drops back to idle
    assign bank_free = bank_ready & ~req_valid;

    // Reads also need room in the order FIFO
    assign cmd_ready = init_calib_complete && bank_free[dec_bank]
                       && !(cmd == CMD_READ && order_full);
    assign accept    = cmd_en && cmd_ready;

    assign order_push = accept && (cmd == CMD_READ);
    assign order_bank = dec_bank;

    always_ff @(posedge clk) begin
        if (rst) begin
            init_cnt            <= '0;
            init_calib_complete <= 1'b0;
            req_valid           <= '0;
        end else begin
            // Handshake with the bank retires the request
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (req_valid[b] && bank_ready[b]) begin
                    req_valid[b] <= 1'b0;
                end
            end
            if (init_issue) begin
                req_valid <= '1;
                init_cnt  <= init_cnt + 1'b1;
            end else if (accept) begin
                req_valid[dec_bank] <= 1'b1;
            end
            // Calibrated after the last clearing write has landed
            if (sweep_done && req_valid == '0 && (&bank_ready)) begin
                init_calib_complete <= 1'b1;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (init_issue) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_req[b] <= init_req;
            end
        end else if (accept) begin
            bank_req[dec_bank] <= cmd_req;
        end
    end

endmodule

/* rtl/mem_ctrl_pkg.sv */
package mem_ctrl_pkg;

    // ************************************************************************
    // Geometry
    // ************************************************************************
    localparam int NUM_BANKS = 4;
    localparam int BANK_BITS = 2;
    localparam int ROWS      = 4;
    localparam int ROW_BITS  = 2;
    localparam int COLS      = 8;
    localparam int COL_BITS  = 3;
    localparam int DATA_W    = 128;
    localparam int STRB_W    = 16;
    localparam int ADDR_W    = 32;

    // ************************************************************************
    // Timing and sizing
    // ************************************************************************
    // Precharge and activate delays in clk cycles
    localparam int T_RP  = 2;
    localparam int T_RCD = 2;
    localparam int WAIT_W = $clog2((T_RP > T_RCD ? T_RP : T_RCD) + 1);

    // One sweep step per row and column pair
    localparam int INIT_CYCLES = ROWS * COLS;
    localparam int INIT_CNT_W  = $clog2(INIT_CYCLES + 1);

    // Read order FIFO
    localparam int ORDER_DEPTH = 8;
    localparam int ORDER_PTR_W = $clog2(ORDER_DEPTH);

    // User opcode, write is cmd low
    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_PRECHARGE,
        BANK_ACTIVATE,
        BANK_ACCESS
    } bank_state_e;

    // Front to bank request
    typedef struct packed {
        mem_cmd_e              op;
        logic [ROW_BITS-1:0]   row;
        logic [COL_BITS-1:0]   col;
        logic [DATA_W-1:0]     data;
        logic [STRB_W-1:0]     strb;
    } bank_req_t;

    // Bank read hold
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } bank_rsp_t;

endpackage

/* rtl/mem_ctrl_top.sv */
`timescale 1ns/1ns

module mem_ctrl_top import mem_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_en,
    input  mem_cmd_e          cmd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic [STRB_W-1:0] wr_strb,
    output logic              cmd_ready,
    output logic              init_calib_complete,
    output logic              rd_data_valid,
    output logic [DATA_W-1:0] rd_data
);

    // Front to banks
    logic [NUM_BANKS-1:0] req_valid;
    bank_req_t            bank_req [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_ready;

    // Banks to return
    bank_rsp_t            bank_rsp [NUM_BANKS];
    logic [NUM_BANKS-1:0] rsp_pop;

    // Read order
    logic                 order_push;
    logic [BANK_BITS-1:0] order_bank;
    logic                 order_full;

    mem_cmd_front u_front (
        .clk                 (clk),
        .rst                 (rst),
        .cmd_en              (cmd_en),
        .cmd                 (cmd),
        .addr                (addr),
        .wr_data             (wr_data),
        .wr_strb             (wr_strb),
        .bank_ready          (bank_ready),
        .order_full          (order_full),
        .cmd_ready           (cmd_ready),
        .init_calib_complete (init_calib_complete),
        .req_valid           (req_valid),
        .bank_req            (bank_req),
        .order_push          (order_push),
        .order_bank          (order_bank)
    );

    // ************************************************************************
    // Bank engines
    // ************************************************************************
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mem_bank_engine u_bank (
            .clk        (clk),
            .rst        (rst),
            .req_valid  (req_valid[b]),
            .bank_req   (bank_req[b]),
            .rsp_pop    (rsp_pop[b]),
            .bank_ready (bank_ready[b]),
            .bank_rsp   (bank_rsp[b])
        );
    end

    mem_read_return u_return (
        .clk           (clk),
        .rst           (rst),
        .order_push    (order_push),
        .order_bank    (order_bank),
        .bank_rsp      (bank_rsp),
        .order_full    (order_full),
        .rsp_pop       (rsp_pop),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data)
    );

endmodule

/* rtl/mem_read_return.sv */
`timescale 1ns/1ns

module mem_read_return import mem_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 order_push,
    input  logic [BANK_BITS-1:0] order_bank,
    input  bank_rsp_t            bank_rsp [NUM_BANKS],
    output logic                 order_full,
    output logic [NUM_BANKS-1:0] rsp_pop,
    output logic                 rd_data_valid,
    output logic [DATA_W-1:0]    rd_data
);

    // Bank number of every outstanding read, oldest at rd_ptr
    logic [BANK_BITS-1:0]   order_mem [ORDER_DEPTH];
    logic [ORDER_PTR_W-1:0] wr_ptr;
    logic [ORDER_PTR_W-1:0] rd_ptr;
    logic [ORDER_PTR_W:0]   count;
    logic [BANK_BITS-1:0]   head_bank;
    logic                   pop;

    assign order_full = (count == (ORDER_PTR_W+1)'(ORDER_DEPTH));
    assign head_bank  = order_mem[rd_ptr];

    // Only the oldest read may leave
    assign pop = (count != '0) && bank_rsp[head_bank].valid;

    always_comb begin
        rsp_pop = '0;
        if (pop) begin
            rsp_pop[head_bank] = 1'b1;
        end
    end

    // ************************************************************************
    // Order FIFO control
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (order_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the level alone
            if (order_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !order_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (order_push) begin
            order_mem[wr_ptr] <= order_bank;
        end
    end

    // Registered read data out
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rd_data <= bank_rsp[head_bank].data;
        end
    end

endmodule

/* sources.f */
rtl/mem_ctrl_pkg.sv
rtl/mem_cmd_front.sv
rtl/mem_bank_engine.sv
rtl/mem_read_return.sv
rtl/mem_ctrl_top.sv
test/mem_ctrl_props.sv
test/mem_ctrl_tb.sv

/* test/mem_ctrl_props.sv */
`timescale 1ns/1ns

module mem_ctrl_props import mem_ctrl_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     cmd_en,
    input mem_cmd_e cmd,
    input logic     cmd_ready,
    input logic     init_calib_complete,
    input logic     rd_data_valid
);

    // Reads taken at the port and not yet returned
    logic [ORDER_PTR_W:0] pending;
    logic                 read_taken;
    int                   fail_count = 0;

    assign read_taken = cmd_en && cmd_ready && (cmd == CMD_READ);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else if (read_taken && !rd_data_valid) begin
            pending <= pending + 1'b1;
        end else if (!read_taken && rd_data_valid) begin
            pending <= pending - 1'b1;
        end
    end

    // ************************************************************************
    // Port rules
    // ************************************************************************
    // No command taken before calibration
    ready_after_init: assert property (@(posedge clk) disable iff (rst)
        cmd_ready |-> init_calib_complete)
        else begin
            $error("cmd_ready high before init_calib_complete");
            fail_count++;
        end

    no_read_before_init: assert property (@(posedge clk) disable iff (rst)
        !init_calib_complete |-> !rd_data_valid)
        else begin
            $error("rd_data_valid high before init_calib_complete");
            fail_count++;
        end

    // Every returned beat belongs to a read still outstanding
    valid_needs_read: assert property (@(posedge clk) disable iff (rst)
        rd_data_valid |-> (pending != '0))
        else begin
            $error("rd_data_valid with no read outstanding");
            fail_count++;
        end

endmodule

bind mem_ctrl_top mem_ctrl_props u_props (
    .clk                 (clk),
    .rst                 (rst),
    .cmd_en              (cmd_en),
    .cmd                 (cmd),
    .cmd_ready           (cmd_ready),
    .init_calib_complete (init_calib_complete),
    .rd_data_valid       (rd_data_valid)
);

/* test/mem_ctrl_tb.sv */
`timescale 1ns/1ns

module mem_ctrl_tb import mem_ctrl_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int WORDS      = NUM_BANKS * ROWS * COLS;
    localparam int RAND_CMDS  = 300;
    localparam int MAX_GAP    = 3;
    // Directed part is a bit under 150 commands
    localparam int TOTAL_CMDS = RAND_CMDS + 150;
    // Twice the worst case of a bank miss plus return plus a gap per command
    localparam int CMD_CYCLES = 2 * (T_RP + T_RCD + 6 + MAX_GAP);
    localparam int WATCHDOG_NS =
        (100 + INIT_CYCLES * (T_RP + T_RCD + 4) + TOTAL_CMDS * CMD_CYCLES) * CLK_PERIOD;

    logic              clk;
    logic              rst;
    logic              cmd_en;
    mem_cmd_e          cmd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;
    logic              cmd_ready;
    logic              init_calib_complete;
    logic              rd_data_valid;
    logic [DATA_W-1:0] rd_data;

    // Reference model
    logic [DATA_W-1:0] shadow [WORDS];
    logic [DATA_W-1:0] exp_q [$];
    string             name_q [$];
    string             test_name;
    integer            seed;
    int                errors;
    int                checks;
    int                reads_sent;
    int                reads_back;

    mem_ctrl_top dut (
        .clk                 (clk),
        .rst                 (rst),
        .cmd_en              (cmd_en),
        .cmd                 (cmd),
        .addr                (addr),
        .wr_data             (wr_data),
        .wr_strb             (wr_strb),
        .cmd_ready           (cmd_ready),
        .init_calib_complete (init_calib_complete),
        .rd_data_valid       (rd_data_valid),
        .rd_data             (rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ************************************************************************
    // Helpers
    // ************************************************************************
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [DATA_W-1:0] random_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Present a command and hold it until accepted
    task automatic send_cmd(input mem_cmd_e op, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s);
        int idx;
        idx = a % WORDS;
        @(negedge clk);
        cmd_en  = 1'b1;
        cmd     = op;
        addr    = a;
        wr_data = d;
        wr_strb = s;
        #1;
        while (!cmd_ready) begin
            @(negedge clk);
            #1;
        end
        // Taken at the coming rising edge
        if (op == CMD_WRITE) begin
            shadow[idx] = merge_bytes(shadow[idx], d, s);
        end else begin
            exp_q.push_back(shadow[idx]);
            name_q.push_back(test_name);
            reads_sent++;
        end
    endtask

    task automatic idle(input int n);
        @(negedge clk);
        cmd_en = 1'b0;
        repeat (n - 1) @(negedge clk);
    endtask

    task automatic drain_reads();
        idle(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
    endtask

    task automatic print_counts();
        $display("checks %0d reads sent %0d reads returned %0d errors %0d",
                 checks, reads_sent, reads_back, errors);
    endtask

    // ************************************************************************
    // Read data checker
    // ************************************************************************
    // Valid pulse is stable between rising edges
    always @(negedge clk) begin
        if (!rst && rd_data_valid) begin
            if (exp_q.size() == 0) begin
                $display("read data returned with no read outstanding");
                errors++;
            end else begin
                checks++;
                reads_back++;
                assert (rd_data === exp_q[0])
                    else begin
                        $display("error %s expected %h actual %h", name_q[0], exp_q[0], rd_data);
                        errors++;
                    end
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired with %0d reads outstanding", exp_q.size());
        print_counts();
        $display("tests failed");
        $finish;
    end

    // ************************************************************************
    // Stimulus
    // ************************************************************************
    initial begin
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        int gap;
        clk = 1'b0;
        rst = 1'b1;
        cmd_en = 1'b0;
        cmd = CMD_WRITE;
        addr = '0;
        wr_data = '0;
        wr_strb = '0;
        seed = 32'h46c1;
        errors = 0;
        checks = 0;
        reads_sent = 0;
        reads_back = 0;
        test_name = "reset";
        // Sweep leaves every word at zero
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (!init_calib_complete) begin
            @(negedge clk);
        end

        test_name = "init_clear";
        for (int i = 0; i < 16; i++) begin
            send_cmd(CMD_READ, $random(seed), '0, '0);
        end
        drain_reads();

        test_name = "full_write";
        for (int i = 0; i < 16; i++) begin
            a = $random(seed);
            send_cmd(CMD_WRITE, a, random_word(), '1);
            send_cmd(CMD_READ, a, '0, '0);
        end
        drain_reads();

        test_name = "partial_strobe";
        for (int i = 0; i < 16; i++) begin
            a = $random(seed);
            send_cmd(CMD_WRITE, a, random_word(), STRB_W'($random(seed)));
            send_cmd(CMD_READ, a, '0, '0);
        end
        drain_reads();

        // Walk banks and rows with repeats for row hits
        test_name = "bank_spread";
        for (int i = 0; i < 24; i++) begin
            a = ((i % NUM_BANKS) << COL_BITS) | (((i / 6) % ROWS) << 5) | (i % COLS);
            send_cmd(CMD_READ, a, '0, '0);
        end
        drain_reads();

        // Same low seven bits but different upper bits
        test_name = "addr_wrap";
        for (int i = 0; i < 16; i++) begin
            a = {$random(seed)} % WORDS;
            d = random_word();
            send_cmd(CMD_WRITE, a | (ADDR_W'($random(seed)) << 7), d, '1);
            send_cmd(CMD_READ, a | (ADDR_W'($random(seed)) << 7), '0, '0);
        end
        drain_reads();

        test_name = "random_mix";
        for (int i = 0; i < RAND_CMDS; i++) begin
            if ($random(seed) & 1) begin
                send_cmd(CMD_READ, $random(seed), '0, '0);
            end else begin
                send_cmd(CMD_WRITE, $random(seed), random_word(), STRB_W'($random(seed)));
            end
            gap = {$random(seed)} % (MAX_GAP + 1);
            if (gap > 0) begin
                idle(gap);
            end
        end
        drain_reads();

        // Each accepted read came back once
        assert (reads_back == reads_sent)
            else begin
                $display("error read_count expected %0d actual %0d", reads_sent, reads_back);
                errors++;
            end

        // Failures seen by the bound port checker
        errors += dut.u_props.fail_count;

        print_counts();
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
